// File: rvDecodePkg.sv
package rvDecodePkg;

    localparam int instrWidth  = 32;
    localparam int xlen        = 64;
    localparam int regIdxWidth = 5;

    typedef logic [instrWidth-1:0]  instrT;
    typedef logic [xlen-1:0]        xlenT;
    typedef logic [regIdxWidth-1:0] regIdxT;
    typedef logic [2:0]             aluOpT;   // add sub xor or and sll srl sra
    typedef logic [3:0]             mulOpT;   // {word, div/rem, funct3[1:0]}
    typedef logic [1:0]             srcSelT;  // A: 0 zero, 1 rs1, 2 pc / B: 0 rs2, 1 imm
    typedef logic [1:0]             flagSelT; // 0 signed less, 1 unsigned less, 2 equal
    typedef logic [3:0]             memModeT; // {store, funct3}

    typedef enum logic [3:0] {
        classR,
        classI,
        classLoad,
        classStore,
        classBranch,
        classJal,
        classJalr,
        classLui,
        classAuipc,
        classUnknown
    } opClassT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ,
        immNone
    } immKindT;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opOp      = 7'b0110011;
    localparam logic [6:0] opOpImm   = 7'b0010011;
    localparam logic [6:0] opOp32    = 7'b0111011;
    localparam logic [6:0] opOpImm32 = 7'b0011011;
    localparam logic [6:0] opLoad    = 7'b0000011;
    localparam logic [6:0] opStore   = 7'b0100011;
    localparam logic [6:0] opBranch  = 7'b1100011;
    localparam logic [6:0] opJal     = 7'b1101111;
    localparam logic [6:0] opJalr    = 7'b1100111;
    localparam logic [6:0] opLui     = 7'b0110111;
    localparam logic [6:0] opAuipc   = 7'b0010111;

    // funct7, instr[31:25]
    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000; // sub, sra
    localparam logic [6:0] f7MulDiv = 7'b0000001; // M extension

endpackage

// File: opcodeClassifier.sv
`timescale 1ns/1ps

module opcodeClassifier (
    input  rvDecodePkg::instrT   instr,
    output rvDecodePkg::opClassT opClass,
    output rvDecodePkg::immKindT immKind,
    output logic                 isBranch,
    output logic                 isJump,
    output logic                 isWriteBack,
    output logic                 isMemWrite,
    output logic                 isMemRead,
    output logic                 rv64,
    output rvDecodePkg::srcSelT  srcA,
    output rvDecodePkg::srcSelT  srcB,
    output rvDecodePkg::memModeT memMode
);

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    always_comb begin
        opClass = rvDecodePkg::classUnknown;
        immKind = rvDecodePkg::immNone;
        rv64    = 1'b0;
        case (opcode)
            rvDecodePkg::opOp: begin
                opClass = rvDecodePkg::classR;
            end
            rvDecodePkg::opOp32: begin
                opClass = rvDecodePkg::classR;
                rv64    = 1'b1; // addw, mulw etc
            end
            rvDecodePkg::opOpImm: begin
                opClass = rvDecodePkg::classI;
                immKind = rvDecodePkg::immI;
            end
            rvDecodePkg::opOpImm32: begin
                opClass = rvDecodePkg::classI;
                immKind = rvDecodePkg::immI;
                rv64    = 1'b1;
            end
            rvDecodePkg::opLoad: begin
                opClass = rvDecodePkg::classLoad;
                immKind = rvDecodePkg::immI;
            end
            rvDecodePkg::opStore: begin
                opClass = rvDecodePkg::classStore;
                immKind = rvDecodePkg::immS;
            end
            rvDecodePkg::opBranch: begin
                opClass = rvDecodePkg::classBranch;
                immKind = rvDecodePkg::immB;
            end
            rvDecodePkg::opJal: begin
                opClass = rvDecodePkg::classJal;
                immKind = rvDecodePkg::immJ;
            end
            rvDecodePkg::opJalr: begin
                opClass = rvDecodePkg::classJalr;
                immKind = rvDecodePkg::immI;
            end
            rvDecodePkg::opLui: begin
                opClass = rvDecodePkg::classLui;
                immKind = rvDecodePkg::immU;
            end
            rvDecodePkg::opAuipc: begin
                opClass = rvDecodePkg::classAuipc;
                immKind = rvDecodePkg::immU;
            end
            default: ; // system and atomic fall here
        endcase
    end

    assign isBranch    = (opClass == rvDecodePkg::classBranch);
    assign isJump      = (opClass == rvDecodePkg::classJal) || (opClass == rvDecodePkg::classJalr);
    assign isMemWrite  = (opClass == rvDecodePkg::classStore);
    assign isMemRead   = (opClass == rvDecodePkg::classLoad);
    assign isWriteBack = !isBranch && !isMemWrite && (opClass != rvDecodePkg::classUnknown);

    assign memMode = {isMemWrite, instr[14:12]}; // width and sign from funct3

    assign srcA = (opClass == rvDecodePkg::classLui)    ? 2'd0 : // zero
                  (opClass == rvDecodePkg::classAuipc)  ? 2'd2 : // pc
                  (opClass == rvDecodePkg::classBranch) ? 2'd2 :
                  (opClass == rvDecodePkg::classJal)    ? 2'd2 :
                  2'd1;                                          // rs1

    assign srcB = (immKind == rvDecodePkg::immNone) ? 2'd0 : 2'd1; // rs2 only for R

endmodule

// File: aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  rvDecodePkg::instrT   instr,
    input  rvDecodePkg::opClassT opClass,
    output rvDecodePkg::aluOpT   aluOp,
    output rvDecodePkg::mulOpT   mulOp,
    output logic                 rvm,
    output logic                 cns,
    output logic                 cmpSrcB,
    output logic                 flagInv,
    output rvDecodePkg::flagSelT useFlag
);

    logic [2:0] funct3;
    logic       isArith;
    logic       isWord;

    assign funct3  = instr[14:12];
    assign isArith = (opClass == rvDecodePkg::classR) || (opClass == rvDecodePkg::classI);
    assign isWord  = (instr[6:0] == rvDecodePkg::opOp32);

    // R and I share one table, only R has sub
    always_comb begin
        aluOp = 3'd0; // add
        if (isArith) begin
            case (funct3)
                3'b000: begin
                    if (opClass == rvDecodePkg::classR && instr[30]) begin
                        aluOp = 3'd1; // sub
                    end
                end
                3'b100: aluOp = 3'd2; // xor
                3'b110: aluOp = 3'd3; // or
                3'b111: aluOp = 3'd4; // and
                3'b001: aluOp = 3'd5; // sll
                3'b101: aluOp = instr[30] ? 3'd7 : 3'd6; // sra / srl
                default: aluOp = 3'd0; // slt, sltu compare through add path
            endcase
        end
    end

    assign rvm   = (opClass == rvDecodePkg::classR) && (instr[31:25] == rvDecodePkg::f7MulDiv);
    assign mulOp = rvm ? {isWord, funct3[2], funct3[1:0]} : 4'b0000;

    // set-less-than forms
    assign cns = isArith && (funct3[2:1] == 2'b01);

    always_comb begin
        useFlag = 2'd0;
        flagInv = 1'b0;
        cmpSrcB = 1'b0;
        if (isArith) begin
            useFlag = funct3[0] ? 2'd1 : 2'd0; // sltu : slt
            cmpSrcB = (opClass == rvDecodePkg::classI); // compare against imm
        end else if (opClass == rvDecodePkg::classBranch) begin
            flagInv = funct3[0]; // bne bge bgeu
            case (funct3[2:1])
                2'b00:   useFlag = 2'd2; // beq bne
                2'b10:   useFlag = 2'd0; // blt bge
                2'b11:   useFlag = 2'd1; // bltu bgeu
                default: useFlag = 2'd0;
            endcase
        end
    end

endmodule

// File: immGenerator.sv
`timescale 1ns/1ps

module immGenerator (
    input  rvDecodePkg::instrT   instr,
    input  rvDecodePkg::immKindT immKind,
    output rvDecodePkg::xlenT    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immKind)
            rvDecodePkg::immI: begin
                imm = {{52{sign}}, instr[31:20]};
            end
            rvDecodePkg::immS: begin
                imm = {{52{sign}}, instr[31:25], instr[11:7]};
            end
            rvDecodePkg::immB: begin
                imm = {{51{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvDecodePkg::immU: begin
                imm = {{32{sign}}, instr[31:12], 12'b0}; // already shifted by 12
            end
            rvDecodePkg::immJ: begin
                imm = {{43{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R and unknown
            end
        endcase
    end

endmodule

// File: legalityChecker.sv
`timescale 1ns/1ps

module legalityChecker (
    input  rvDecodePkg::instrT   instr,
    input  rvDecodePkg::opClassT opClass,
    output logic                 illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isWord;
    logic       f7Base;
    logic       f7Alt;
    logic       f7Mul;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign isWord = (instr[6:0] == rvDecodePkg::opOp32) || (instr[6:0] == rvDecodePkg::opOpImm32);
    assign f7Base = (funct7 == rvDecodePkg::f7Base);
    assign f7Alt  = (funct7 == rvDecodePkg::f7Alt);
    assign f7Mul  = (funct7 == rvDecodePkg::f7MulDiv);

    always_comb begin
        illegal = 1'b0;
        case (opClass)
            rvDecodePkg::classR: begin
                case (funct3)
                    3'b000, 3'b101: illegal = !(f7Base || f7Alt || f7Mul); // add sub mul, srl sra divu
                    3'b001:         illegal = isWord ? !f7Base : !(f7Base || f7Mul); // sll mulh
                    3'b010, 3'b011: illegal = isWord || !(f7Base || f7Mul); // slt and upper mul
                    default:        illegal = isWord ? !f7Mul : !(f7Base || f7Mul);
                endcase
            end
            rvDecodePkg::classI: begin
                if (isWord) begin
                    case (funct3)
                        3'b000:  illegal = 1'b0;              // addiw
                        3'b001:  illegal = !f7Base;           // slliw, 5 bit shamt
                        3'b101:  illegal = !(f7Base || f7Alt); // srliw sraiw
                        default: illegal = 1'b1;
                    endcase
                end else begin
                    case (funct3)
                        3'b001:  illegal = (funct7[6:1] != 6'b000000); // 6 bit shamt
                        3'b101:  illegal = (funct7[6:1] != 6'b000000) &&
                                           (funct7[6:1] != 6'b010000);
                        default: illegal = 1'b0;
                    endcase
                end
            end
            rvDecodePkg::classLoad: begin
                illegal = (funct3 == 3'b111); // no ldu
            end
            rvDecodePkg::classStore: begin
                illegal = funct3[2]; // sb sh sw sd only
            end
            rvDecodePkg::classBranch: begin
                illegal = (funct3[2:1] == 2'b01);
            end
            rvDecodePkg::classJalr: begin
                illegal = (funct3 != 3'b000);
            end
            rvDecodePkg::classJal, rvDecodePkg::classLui, rvDecodePkg::classAuipc: begin
                illegal = 1'b0;
            end
            default: begin
                illegal = 1'b1; // unsupported opcode
            end
        endcase
    end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  rvDecodePkg::instrT   instr,
    input  logic                 instrValid,
    input  logic                 stall,
    output logic                 decValid,
    output rvDecodePkg::xlenT    imm,
    output rvDecodePkg::regIdxT  rs1,
    output rvDecodePkg::regIdxT  rs2,
    output rvDecodePkg::regIdxT  rd,
    output rvDecodePkg::aluOpT   aluOp,
    output rvDecodePkg::mulOpT   mulOp,
    output logic                 rv64,
    output logic                 rvm,
    output rvDecodePkg::srcSelT  srcA,
    output rvDecodePkg::srcSelT  srcB,
    output logic                 isBranch,
    output logic                 isJump,
    output logic                 isWriteBack,
    output logic                 isMemWrite,
    output logic                 isMemRead,
    output rvDecodePkg::memModeT memMode,
    output logic                 cns,
    output logic                 cmpSrcB,
    output logic                 flagInv,
    output rvDecodePkg::flagSelT useFlag,
    output logic                 illegal
);

    rvDecodePkg::opClassT opClass;
    rvDecodePkg::immKindT immKind;
    rvDecodePkg::xlenT    nextImm;
    rvDecodePkg::aluOpT   nextAluOp;
    rvDecodePkg::mulOpT   nextMulOp;
    rvDecodePkg::srcSelT  nextSrcA;
    rvDecodePkg::srcSelT  nextSrcB;
    rvDecodePkg::memModeT nextMemMode;
    rvDecodePkg::flagSelT nextUseFlag;
    logic nextRv64;
    logic nextRvm;
    logic nextBranch;
    logic nextJump;
    logic nextWriteBack;
    logic nextMemWrite;
    logic nextMemRead;
    logic nextCns;
    logic nextCmpSrcB;
    logic nextFlagInv;
    logic nextIllegal;

    opcodeClassifier uClassifier (
        .instr(instr), .opClass(opClass), .immKind(immKind),
        .isBranch(nextBranch), .isJump(nextJump), .isWriteBack(nextWriteBack),
        .isMemWrite(nextMemWrite), .isMemRead(nextMemRead), .rv64(nextRv64),
        .srcA(nextSrcA), .srcB(nextSrcB), .memMode(nextMemMode)
    );

    aluControl uAluControl (
        .instr(instr), .opClass(opClass), .aluOp(nextAluOp), .mulOp(nextMulOp),
        .rvm(nextRvm), .cns(nextCns), .cmpSrcB(nextCmpSrcB), .flagInv(nextFlagInv),
        .useFlag(nextUseFlag)
    );

    immGenerator uImmGen (.instr(instr), .immKind(immKind), .imm(nextImm));

    legalityChecker uLegality (.instr(instr), .opClass(opClass), .illegal(nextIllegal));

    // control flags, cleared on reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid    <= 1'b0;
            isBranch    <= 1'b0;
            isJump      <= 1'b0;
            isWriteBack <= 1'b0;
            isMemWrite  <= 1'b0;
            isMemRead   <= 1'b0;
            illegal     <= 1'b0;
        end else if (!stall) begin
            decValid    <= instrValid;
            isBranch    <= nextBranch;
            isJump      <= nextJump;
            isWriteBack <= nextWriteBack;
            isMemWrite  <= nextMemWrite;
            isMemRead   <= nextMemRead;
            illegal     <= nextIllegal;
        end
    end

    // payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            imm     <= nextImm;
            rs1     <= instr[19:15];
            rs2     <= instr[24:20];
            rd      <= instr[11:7];
            aluOp   <= nextAluOp;
            mulOp   <= nextMulOp;
            rv64    <= nextRv64;
            rvm     <= nextRvm;
            srcA    <= nextSrcA;
            srcB    <= nextSrcB;
            memMode <= nextMemMode;
            cns     <= nextCns;
            cmpSrcB <= nextCmpSrcB;
            flagInv <= nextFlagInv;
            useFlag <= nextUseFlag;
        end
    end

endmodule

// File: decodeRef.svh
// expected outputs of the decode stage for one word
typedef struct packed {
    rvDecodePkg::xlenT    imm;
    rvDecodePkg::regIdxT  rs1;
    rvDecodePkg::regIdxT  rs2;
    rvDecodePkg::regIdxT  rd;
    rvDecodePkg::aluOpT   aluOp;
    rvDecodePkg::mulOpT   mulOp;
    logic                 rv64;
    logic                 rvm;
    rvDecodePkg::srcSelT  srcA;
    rvDecodePkg::srcSelT  srcB;
    logic                 isBranch;
    logic                 isJump;
    logic                 isWriteBack;
    logic                 isMemWrite;
    logic                 isMemRead;
    rvDecodePkg::memModeT memMode;
    logic                 cns;
    logic                 cmpSrcB;
    logic                 flagInv;
    rvDecodePkg::flagSelT useFlag;
    logic                 illegal;
} decExpT;

function automatic decExpT decodeRef(input rvDecodePkg::instrT w);
    decExpT     e;
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       isR;
    logic       isI;
    logic       word;
    logic       known;
    e     = '0;
    op    = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    isR   = (op == rvDecodePkg::opOp) || (op == rvDecodePkg::opOp32);
    isI   = (op == rvDecodePkg::opOpImm) || (op == rvDecodePkg::opOpImm32);
    word  = (op == rvDecodePkg::opOp32) || (op == rvDecodePkg::opOpImm32);
    known = isR || isI || op inside {rvDecodePkg::opLoad, rvDecodePkg::opStore,
            rvDecodePkg::opBranch, rvDecodePkg::opJal, rvDecodePkg::opJalr,
            rvDecodePkg::opLui, rvDecodePkg::opAuipc};
    e.rs1         = w[19:15];
    e.rs2         = w[24:20];
    e.rd          = w[11:7];
    e.rv64        = word;
    e.isBranch    = (op == rvDecodePkg::opBranch);
    e.isJump      = (op == rvDecodePkg::opJal) || (op == rvDecodePkg::opJalr);
    e.isMemWrite  = (op == rvDecodePkg::opStore);
    e.isMemRead   = (op == rvDecodePkg::opLoad);
    e.isWriteBack = known && !e.isBranch && !e.isMemWrite;
    e.memMode     = {e.isMemWrite, f3};
    e.srcB        = (isR || !known) ? 2'd0 : 2'd1;
    if (op == rvDecodePkg::opLui) e.srcA = 2'd0;
    else if (op inside {rvDecodePkg::opAuipc, rvDecodePkg::opBranch, rvDecodePkg::opJal})
        e.srcA = 2'd2;
    else e.srcA = 2'd1;
    // immediate by format
    if (isI || op inside {rvDecodePkg::opLoad, rvDecodePkg::opJalr})
        e.imm = {{52{w[31]}}, w[31:20]};
    else if (op == rvDecodePkg::opStore) e.imm = {{52{w[31]}}, w[31:25], w[11:7]};
    else if (op == rvDecodePkg::opBranch)
        e.imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    else if (op inside {rvDecodePkg::opLui, rvDecodePkg::opAuipc})
        e.imm = {{32{w[31]}}, w[31:12], 12'h000};
    else if (op == rvDecodePkg::opJal)
        e.imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    if (isR || isI) begin
        case (f3)
            3'b000: e.aluOp = (isR && w[30]) ? 3'd1 : 3'd0;
            3'b001: e.aluOp = 3'd5;
            3'b100: e.aluOp = 3'd2;
            3'b101: e.aluOp = w[30] ? 3'd7 : 3'd6;
            3'b110: e.aluOp = 3'd3;
            3'b111: e.aluOp = 3'd4;
            default: e.aluOp = 3'd0;
        endcase
        e.cns     = (f3 == 3'd2) || (f3 == 3'd3);
        e.useFlag = {1'b0, f3[0]};
        e.cmpSrcB = isI;
    end
    e.rvm   = isR && (f7 == rvDecodePkg::f7MulDiv);
    e.mulOp = e.rvm ? {op == rvDecodePkg::opOp32, f3} : 4'd0;
    if (e.isBranch) begin
        e.flagInv = f3[0];
        if (f3[2:1] == 2'b00) e.useFlag = 2'd2;
        else if (f3[2:1] == 2'b11) e.useFlag = 2'd1;
    end
    // validity table of the supported subset
    if (isR) begin
        if (f3 == 3'd0 || f3 == 3'd5) e.illegal = !(f7 inside {7'h00, 7'h20, 7'h01});
        else if (f3 == 3'd1) e.illegal = word ? (f7 != 7'h00) : !(f7 inside {7'h00, 7'h01});
        else if (f3 == 3'd2 || f3 == 3'd3) e.illegal = word || !(f7 inside {7'h00, 7'h01});
        else e.illegal = word ? (f7 != 7'h01) : !(f7 inside {7'h00, 7'h01});
    end else if (isI && word) begin
        if (f3 == 3'd0) e.illegal = 1'b0;
        else if (f3 == 3'd1) e.illegal = (f7 != 7'h00);
        else if (f3 == 3'd5) e.illegal = !(f7 inside {7'h00, 7'h20});
        else e.illegal = 1'b1;
    end else if (isI) begin
        if (f3 == 3'd1) e.illegal = (w[31:26] != 6'h00);
        else if (f3 == 3'd5) e.illegal = !(w[31:26] inside {6'h00, 6'h10});
    end else if (op == rvDecodePkg::opLoad) e.illegal = (f3 == 3'd7);
    else if (op == rvDecodePkg::opStore) e.illegal = f3[2];
    else if (op == rvDecodePkg::opBranch) e.illegal = (f3 == 3'd2) || (f3 == 3'd3);
    else if (op == rvDecodePkg::opJalr) e.illegal = (f3 != 3'd0);
    else e.illegal = !known;
    return e;
endfunction

// File: rvDecodeTb.sv
`timescale 1ns/1ps

module rvDecodeTb;

    logic clk;
    logic rstN;
    rvDecodePkg::instrT instr;
    logic instrValid;
    logic stall;
    logic decValid;
    rvDecodePkg::xlenT imm;
    rvDecodePkg::regIdxT rs1, rs2, rd;
    rvDecodePkg::aluOpT aluOp;
    rvDecodePkg::mulOpT mulOp;
    logic rv64, rvm, isBranch, isJump, isWriteBack, isMemWrite, isMemRead;
    rvDecodePkg::srcSelT srcA, srcB;
    rvDecodePkg::memModeT memMode;
    logic cns, cmpSrcB, flagInv, illegal;
    rvDecodePkg::flagSelT useFlag;

    int seed;
    int errors;
    int checks;
    logic stallMode;
    logic captured;
    logic accepted;
    logic heldValid;
    rvDecodePkg::instrT pending[$];
    localparam logic [6:0] fmtOps[8] = '{rvDecodePkg::opOpImm, rvDecodePkg::opLoad,
        rvDecodePkg::opJalr, rvDecodePkg::opStore, rvDecodePkg::opBranch,
        rvDecodePkg::opJal, rvDecodePkg::opLui, rvDecodePkg::opAuipc};

    `include "decodeRef.svh"

    decExpT lastExp;

    decodeStage dut (
        .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid), .stall(stall),
        .decValid(decValid), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd), .aluOp(aluOp),
        .mulOp(mulOp), .rv64(rv64), .rvm(rvm), .srcA(srcA), .srcB(srcB),
        .isBranch(isBranch), .isJump(isJump), .isWriteBack(isWriteBack),
        .isMemWrite(isMemWrite), .isMemRead(isMemRead), .memMode(memMode), .cns(cns),
        .cmpSrcB(cmpSrcB), .flagInv(flagInv), .useFlag(useFlag), .illegal(illegal)
    );

    always #10 clk = ~clk; // 20 ns period

    task automatic reportErr(string name, logic [63:0] exp, logic [63:0] act);
        errors++;
        $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
    endtask

    task automatic checkXlen(string name, rvDecodePkg::xlenT exp, rvDecodePkg::xlenT act);
        checks++;
        if (exp !== act) reportErr(name, exp, act);
    endtask

    task automatic checkRegIdx(string name, rvDecodePkg::regIdxT exp, rvDecodePkg::regIdxT act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic checkAluOp(string name, rvDecodePkg::aluOpT exp, rvDecodePkg::aluOpT act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic checkMulOp(string name, rvDecodePkg::mulOpT exp, rvDecodePkg::mulOpT act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic checkSrcSel(string name, rvDecodePkg::srcSelT exp, rvDecodePkg::srcSelT act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic checkFlagSel(string name, rvDecodePkg::flagSelT exp,
                                rvDecodePkg::flagSelT act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic checkMemMode(string name, rvDecodePkg::memModeT exp,
                                rvDecodePkg::memModeT act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        checks++;
        if (exp !== act) reportErr(name, 64'(exp), 64'(act));
    endtask

    task automatic compareAll(decExpT e);
        checkXlen("imm", e.imm, imm);
        checkRegIdx("rs1", e.rs1, rs1);
        checkRegIdx("rs2", e.rs2, rs2);
        checkRegIdx("rd", e.rd, rd);
        checkAluOp("aluOp", e.aluOp, aluOp);
        checkMulOp("mulOp", e.mulOp, mulOp);
        checkSrcSel("srcA", e.srcA, srcA);
        checkSrcSel("srcB", e.srcB, srcB);
        checkFlagSel("useFlag", e.useFlag, useFlag);
        checkMemMode("memMode", e.memMode, memMode);
        checkBit("rv64", e.rv64, rv64);
        checkBit("rvm", e.rvm, rvm);
        checkBit("isBranch", e.isBranch, isBranch);
        checkBit("isJump", e.isJump, isJump);
        checkBit("isWriteBack", e.isWriteBack, isWriteBack);
        checkBit("isMemWrite", e.isMemWrite, isMemWrite);
        checkBit("isMemRead", e.isMemRead, isMemRead);
        checkBit("cns", e.cns, cns);
        checkBit("cmpSrcB", e.cmpSrcB, cmpSrcB);
        checkBit("flagInv", e.flagInv, flagInv);
        checkBit("illegal", e.illegal, illegal);
    endtask

    // what the DUT sampled at this edge
    always @(posedge clk) begin
        captured = rstN && !stall;
        accepted = captured && instrValid;
        if (accepted) pending.push_back(instr);
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (rstN && captured) begin
            checkBit("decValid", accepted, decValid);
            heldValid = accepted;
            if (accepted && decValid) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("output shown with no accepted word at t=%0t", $time);
                end else begin
                    lastExp = decodeRef(pending.pop_front());
                    compareAll(lastExp);
                end
            end
        end else if (rstN) begin
            checkBit("decValid", heldValid, decValid); // stalled, must hold
            if (heldValid) compareAll(lastExp);
        end
    end

    task automatic abortRun(string why);
        $display("%s at t=%0t", why, $time);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    function automatic logic pickStall();
        int r;
        r = $random(seed);
        return stallMode && r[0];
    endfunction

    // one word per reset cycle, each would raise a different flag
    function automatic rvDecodePkg::instrT resetWord(int i);
        case (i)
            0:       return 32'h0000_0003; // lb
            1:       return 32'h0000_0023; // sb
            2:       return 32'h0000_0063; // beq
            3:       return 32'h0000_006f; // jal
            default: return 32'h0000_0073; // system opcode
        endcase
    endfunction

    task automatic sendWord(rvDecodePkg::instrT w);
        int tries;
        tries = 0;
        instr      <= w;
        instrValid <= 1'b1;
        stall      <= pickStall();
        @(posedge clk);
        while (stall) begin
            tries++;
            if (tries > 50) abortRun("word never accepted");
            stall <= pickStall();
            @(posedge clk);
        end
    endtask

    task automatic drain(string name, int errsBefore);
        int n;
        n = 0;
        instrValid <= 1'b0;
        stall      <= 1'b0;
        @(posedge clk);
        while (pending.size() != 0) begin
            n++;
            if (n > 20) abortRun("pending words never left the stage");
            @(posedge clk);
        end
        @(posedge clk);
        $display("test %s: %0d errors", name, errors - errsBefore);
    endtask

    function automatic rvDecodePkg::instrT makeArith();
        rvDecodePkg::instrT w;
        decExpT e;
        int k;
        for (int t = 0; t < 32; t++) begin
            w = $random(seed);
            k = $random(seed);
            case (k[1:0])
                2'd0: w[6:0] = rvDecodePkg::opOp;
                2'd1: w[6:0] = rvDecodePkg::opOp32;
                2'd2: w[6:0] = rvDecodePkg::opOpImm;
                default: w[6:0] = rvDecodePkg::opOpImm32;
            endcase
            if (k[3:2] == 2'd1) w[31:25] = rvDecodePkg::f7Alt;
            else if (k[3:2] == 2'd2) w[31:25] = rvDecodePkg::f7MulDiv;
            else if (k[3:2] == 2'd3) w[31:25] = rvDecodePkg::f7Base;
            e = decodeRef(w);
            if (!e.illegal) break;
        end
        return w;
    endfunction

    function automatic rvDecodePkg::instrT makeFormat(logic ctrlOnly);
        rvDecodePkg::instrT w;
        int k;
        w = $random(seed);
        k = $random(seed);
        w[6:0] = fmtOps[ctrlOnly ? 1 + (k[15:0] % 7) : k[2:0]];
        return w;
    endfunction

    initial begin
        int mark;
        rvDecodePkg::instrT w;
        clk        = 1'b0;
        seed       = 32'haa18;
        errors     = 0;
        checks     = 0;
        stallMode  = 1'b0;
        heldValid  = 1'b0;
        rstN       <= 1'b0;
        instr      <= resetWord(0);
        instrValid <= 1'b1; // valid words must not get past reset
        stall      <= 1'b0;
        mark = errors;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i < 4) begin
                instr <= resetWord(i + 1);
            end else begin
                rstN       <= 1'b1;
                instrValid <= 1'b0;
            end
            @(negedge clk);
            checkBit("decValid", 1'b0, decValid);
            checkBit("isBranch", 1'b0, isBranch);
            checkBit("isJump", 1'b0, isJump);
            checkBit("isWriteBack", 1'b0, isWriteBack);
            checkBit("isMemWrite", 1'b0, isMemWrite);
            checkBit("isMemRead", 1'b0, isMemRead);
            checkBit("illegal", 1'b0, illegal);
        end
        $display("test reset: %0d errors", errors - mark);
        @(posedge clk);
        mark = errors;
        for (int i = 0; i < 200; i++) sendWord(makeArith());
        drain("arithmetic", mark);
        mark = errors;
        for (int i = 0; i < 200; i++) sendWord(makeFormat(1'b0));
        drain("immediates", mark);
        mark = errors;
        for (int i = 0; i < 200; i++) sendWord(makeFormat(1'b1));
        drain("control", mark);
        mark = errors;
        sendWord(32'h3000_2073); // csr opcode
        sendWord(32'h0805_b02f); // atomic opcode
        for (int i = 0; i < 300; i++) begin
            w = $random(seed);
            sendWord(w);
        end
        drain("illegal", mark);
        mark = errors;
        stallMode = 1'b1;
        for (int i = 0; i < 300; i++) begin
            w = (i % 3 == 0) ? makeArith() : makeFormat(1'b0);
            sendWord(w);
        end
        stallMode = 1'b0;
        drain("stall", mark);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rvDecode.f
+incdir+.
rvDecodePkg.sv
opcodeClassifier.sv
aluControl.sv
immGenerator.sv
legalityChecker.sv
decodeStage.sv
rvDecodeTb.sv

// File: Makefile
# Verilator flow for the decode stage testbench
VERILATOR ?= verilator
TOP       ?= rvDecodeTb
FILELIST  ?= rvDecode.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
